/* Bender.yml */
package:
  name: mdu

export_include_dirs:
  - hdl

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/mdu_data_pkg.sv
      - hdl/mdu_ctrl_pkg.sv
      - hdl/mdu_decode.sv
      - hdl/mdu_multiplier.sv
      - hdl/mdu_divider.sv
      - hdl/mdu_result.sv
      - hdl/mdu_top.sv
  - target: simulation
    include_dirs:
      - hdl
    files:
      - sim/mdu_tb.sv

/* hdl/mdu_ctrl_pkg.sv */
// Pipeline records of the multiply/divide unit: request, decoded issue, response and divider FSM
`default_nettype none

`include "mdu_params.svh"

package mdu_ctrl_pkg;
  import mdu_data_pkg::*;

  typedef struct packed {
    md_op_e op;
    word_t  a;
    word_t  b;
  } md_req_t;

  typedef struct packed {
    md_op_e op;             // Echoed into the response
    logic   a_signed;
    logic   b_signed;
    logic   is_div;
    logic   want_high;      // High product word or remainder
    logic   special;        // Divide by zero or signed overflow
    word_t  special_value;  // Result used when special is set
    word_t  a;
    word_t  b;
  } md_issue_t;

  typedef struct packed {
    md_op_e op;
    word_t  result;
  } md_resp_t;

  typedef enum logic [1:0] {div_idle, div_count, div_fix, div_done} div_state_e;

endpackage

`default_nettype wire

/* hdl/mdu_data_pkg.sv */
// Operand-level types of the multiply/divide unit; import wherever words or ops are used
`default_nettype none

`include "mdu_params.svh"

package mdu_data_pkg;

  typedef logic [`MDU_XLEN-1:0]   word_t;   // Operand or result word
  typedef logic [2*`MDU_XLEN-1:0] dword_t;  // Full product, divider shift register

  // Encoded as RV32M funct3
  typedef enum logic [2:0] {
    op_mul    = 3'b000,
    op_mulh   = 3'b001,
    op_mulhsu = 3'b010,
    op_mulhu  = 3'b011,
    op_div    = 3'b100,
    op_divu   = 3'b101,
    op_rem    = 3'b110,
    op_remu   = 3'b111
  } md_op_e;

endpackage

`default_nettype wire

/* hdl/mdu_decode.sv */
// Request stage: accepts one operation, decodes signedness and result half, flags special divides
`default_nettype none

`include "mdu_params.svh"

module mdu_decode import mdu_data_pkg::*, mdu_ctrl_pkg::*; (
  input  logic      clock,
  input  logic      reset,
  input  logic      flush,
  input  logic      req_valid,
  input  md_req_t   req,
  output logic      req_ready,
  input  logic      resp_valid,
  output logic      issue_valid,
  output md_issue_t issue
);

  logic      accept;
  logic      busy;
  logic      div_zero;
  logic      div_ovf;
  md_issue_t next_issue;

  assign accept    = req_valid & req_ready;
  assign req_ready = ~busy;

  always_comb begin
    next_issue.op        = req.op;
    next_issue.a         = req.a;
    next_issue.b         = req.b;
    next_issue.a_signed  = req.op inside {op_mulh, op_mulhsu, op_div, op_rem};
    next_issue.b_signed  = req.op inside {op_mulh, op_div, op_rem};
    next_issue.is_div    = req.op inside {op_div, op_divu, op_rem, op_remu};
    next_issue.want_high = req.op inside {op_mulh, op_mulhsu, op_mulhu, op_rem, op_remu};

    div_zero = next_issue.is_div & (req.b == '0);
    // Most negative dividend over minus one
    div_ovf  = next_issue.is_div & next_issue.b_signed & (req.b == '1)
               & (req.a == word_t'({1'b1, {(`MDU_XLEN-1){1'b0}}}));

    next_issue.special = div_zero | div_ovf;
    if (div_zero) begin
      next_issue.special_value = next_issue.want_high ? req.a : '1;
    end else if (div_ovf) begin
      next_issue.special_value = next_issue.want_high ? '0 : req.a;
    end else begin
      next_issue.special_value = '0;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      busy        <= 1'b0;
      issue_valid <= 1'b0;
    end else begin
      issue_valid <= accept;  // An acceptance survives a flush in its own cycle
      if (accept) begin
        busy <= 1'b1;
      end else if (flush | resp_valid) begin
        busy <= 1'b0;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (accept) begin
      issue <= next_issue;
    end
  end

endmodule

`default_nettype wire

/* hdl/mdu_divider.sv */
// Divide path: restoring divider, one quotient bit per cycle on magnitudes, signs fixed at the end
`default_nettype none

`include "mdu_params.svh"

module mdu_divider import mdu_data_pkg::*, mdu_ctrl_pkg::*; (
  input  logic  clock,
  input  logic  reset,
  input  logic  flush,
  input  logic  start,
  input  word_t dividend,
  input  word_t divisor,
  input  logic  dividend_signed,
  input  logic  divisor_signed,
  output logic  div_valid,
  output word_t quotient,
  output word_t remainder
);

  typedef logic [$clog2(`MDU_DIV_STEPS)-1:0] step_t;

  div_state_e          state;
  step_t               step;
  logic                dividend_neg;
  logic                divisor_neg;
  word_t               dividend_abs;
  word_t               divisor_abs;
  dword_t              shift_q;     // Partial remainder over remaining dividend bits
  word_t               divisor_q;
  word_t               quot_q;
  logic                neg_quot_q;
  logic                neg_rem_q;
  logic [`MDU_XLEN:0]  trial;
  logic                fits;

  assign dividend_neg = dividend_signed & dividend[`MDU_XLEN-1];
  assign divisor_neg  = divisor_signed & divisor[`MDU_XLEN-1];
  assign dividend_abs = dividend_neg ? -dividend : dividend;
  assign divisor_abs  = divisor_neg ? -divisor : divisor;

  // Borrow out of the trial subtraction means the divisor does not fit
  assign trial = shift_q[2*`MDU_XLEN-1:`MDU_XLEN-1] - {1'b0, divisor_q};
  assign fits  = ~trial[`MDU_XLEN];

  assign div_valid = (state == div_done);

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= div_idle;
      step  <= '0;
    end else if (flush) begin
      state <= div_idle;
    end else begin
      unique case (state)
        div_idle: begin
          if (start) begin
            state <= div_count;
            step  <= step_t'(`MDU_DIV_STEPS - 1);
          end
        end
        div_count: begin
          step <= step - 1'b1;
          if (step == '0) begin
            state <= div_fix;
          end
        end
        div_fix:  state <= div_done;
        div_done: state <= div_idle;
        default:  state <= div_idle;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    unique case (state)
      div_idle: begin
        if (start) begin
          shift_q    <= {{`MDU_XLEN{1'b0}}, dividend_abs};
          divisor_q  <= divisor_abs;
          quot_q     <= '0;
          neg_quot_q <= dividend_neg ^ divisor_neg;
          neg_rem_q  <= dividend_neg;              // Remainder follows the dividend
        end
      end
      div_count: begin
        if (fits) begin
          shift_q <= {trial[`MDU_XLEN-1:0], shift_q[`MDU_XLEN-2:0], 1'b0};
        end else begin
          shift_q <= {shift_q[2*`MDU_XLEN-2:0], 1'b0};
        end
        quot_q <= {quot_q[`MDU_XLEN-2:0], fits};
      end
      div_fix: begin
        quotient  <= neg_quot_q ? -quot_q : quot_q;
        remainder <= neg_rem_q ? -shift_q[2*`MDU_XLEN-1:`MDU_XLEN]
                               : shift_q[2*`MDU_XLEN-1:`MDU_XLEN];
      end
      default: ;
    endcase
  end

endmodule

`default_nettype wire

/* hdl/mdu_multiplier.sv */
// Multiply path: one registered 33x33 signed product, high or low word handed to the result stage
`default_nettype none

`include "mdu_params.svh"

module mdu_multiplier import mdu_data_pkg::*, mdu_ctrl_pkg::*; (
  input  logic      clock,
  input  logic      reset,
  input  logic      flush,
  input  logic      issue_valid,
  input  md_issue_t issue,
  output logic      mul_valid,
  output word_t     mul_word
);

  logic                          start;
  logic signed [`MDU_XLEN:0]     a_ext;
  logic signed [`MDU_XLEN:0]     b_ext;
  logic signed [2*`MDU_XLEN+1:0] prod_full;
  dword_t                        prod_q;
  logic                          high_q;

  assign start = issue_valid & ~issue.is_div;

  // Extra top bit makes MULHU and MULHSU fit a signed multiply
  assign a_ext = {issue.a_signed & issue.a[`MDU_XLEN-1], issue.a};
  assign b_ext = {issue.b_signed & issue.b[`MDU_XLEN-1], issue.b};

  assign prod_full = a_ext * b_ext;

  always_ff @(posedge clock) begin
    if (reset) begin
      mul_valid <= 1'b0;
    end else begin
      mul_valid <= start & ~flush;
    end
  end

  always_ff @(posedge clock) begin
    if (start) begin
      prod_q <= prod_full[2*`MDU_XLEN-1:0];  // Top two bits are sign copies
      high_q <= issue.want_high;
    end
  end

  assign mul_word = high_q ? prod_q[2*`MDU_XLEN-1:`MDU_XLEN] : prod_q[`MDU_XLEN-1:0];

endmodule

`default_nettype wire

/* hdl/mdu_params.svh */
// Width macros for the multiply/divide unit, included by packages, RTL and testbench
`ifndef MDU_PARAMS_SVH
`define MDU_PARAMS_SVH

// Operand and result width, fixed by RV32
`define MDU_XLEN 32

// One quotient bit per divider iteration
`define MDU_DIV_STEPS 32

`endif

/* hdl/mdu_result.sv */
// Response stage: gates divider start, answers special divides and registers the single response
`default_nettype none

module mdu_result import mdu_data_pkg::*, mdu_ctrl_pkg::*; (
  input  logic      clock,
  input  logic      reset,
  input  logic      flush,
  input  logic      issue_valid,
  input  md_issue_t issue,
  output logic      div_start,
  input  logic      mul_valid,
  input  word_t     mul_word,
  input  logic      div_valid,
  input  word_t     quotient,
  input  word_t     remainder,
  output logic      resp_valid,
  output md_resp_t  resp
);

  logic   special_hit;
  logic   want_high_q;
  md_op_e op_q;

  assign special_hit = issue_valid & issue.special;

  // Special cases never occupy the divider
  assign div_start = issue_valid & issue.is_div & ~issue.special;

  always_ff @(posedge clock) begin
    if (issue_valid) begin
      want_high_q <= issue.want_high;
      op_q        <= issue.op;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      resp_valid <= 1'b0;
    end else begin
      resp_valid <= ~flush & (special_hit | mul_valid | div_valid);
    end
  end

  always_ff @(posedge clock) begin
    if (special_hit) begin
      resp.op     <= issue.op;  // Latched copy not yet loaded
      resp.result <= issue.special_value;
    end else if (mul_valid) begin
      resp.op     <= op_q;
      resp.result <= mul_word;
    end else if (div_valid) begin
      resp.op     <= op_q;
      resp.result <= want_high_q ? remainder : quotient;
    end
  end

endmodule

`default_nettype wire

/* hdl/mdu_top.sv */
// RV32M multiply/divide unit top: decode, multiply and divide paths, response merge
`default_nettype none

module mdu_top import mdu_data_pkg::*, mdu_ctrl_pkg::*; (
  input  logic     clock,
  input  logic     reset,
  input  logic     flush,
  input  logic     req_valid,
  input  md_req_t  req,
  output logic     req_ready,
  output logic     resp_valid,
  output md_resp_t resp
);

  logic      issue_valid;
  md_issue_t issue;
  logic      mul_valid;
  word_t     mul_word;
  logic      div_start;
  logic      div_valid;
  word_t     quotient;
  word_t     remainder;

  mdu_decode i_decode (
    .clock       (clock),
    .reset       (reset),
    .flush       (flush),
    .req_valid   (req_valid),
    .req         (req),
    .req_ready   (req_ready),
    .resp_valid  (resp_valid),
    .issue_valid (issue_valid),
    .issue       (issue)
  );

  mdu_multiplier i_multiplier (
    .clock       (clock),
    .reset       (reset),
    .flush       (flush),
    .issue_valid (issue_valid),
    .issue       (issue),
    .mul_valid   (mul_valid),
    .mul_word    (mul_word)
  );

  mdu_divider i_divider (
    .clock           (clock),
    .reset           (reset),
    .flush           (flush),
    .start           (div_start),
    .dividend        (issue.a),
    .divisor         (issue.b),
    .dividend_signed (issue.a_signed),
    .divisor_signed  (issue.b_signed),
    .div_valid       (div_valid),
    .quotient        (quotient),
    .remainder       (remainder)
  );

  mdu_result i_result (
    .clock       (clock),
    .reset       (reset),
    .flush       (flush),
    .issue_valid (issue_valid),
    .issue       (issue),
    .div_start   (div_start),
    .mul_valid   (mul_valid),
    .mul_word    (mul_word),
    .div_valid   (div_valid),
    .quotient    (quotient),
    .remainder   (remainder),
    .resp_valid  (resp_valid),
    .resp        (resp)
  );

endmodule

`default_nettype wire

/* mdu_top.f */
+incdir+hdl
hdl/mdu_data_pkg.sv
hdl/mdu_ctrl_pkg.sv
hdl/mdu_decode.sv
hdl/mdu_multiplier.sv
hdl/mdu_divider.sv
hdl/mdu_result.sv
hdl/mdu_top.sv
sim/mdu_tb.sv

/* sim/mdu_tb.sv */
// Self-checking testbench for the multiply/divide unit top with table, flush and random model tests
`default_nettype none

`include "mdu_params.svh"

module mdu_tb import mdu_data_pkg::*, mdu_ctrl_pkg::*; ();

  localparam int    timeout_cycles = 100;
  localparam int    num_tests      = 29;
  localparam int    num_random     = 200;
  localparam word_t min_word       = {1'b1, {(`MDU_XLEN-1){1'b0}}};
  localparam word_t ones_word      = '1;

  typedef struct packed {
    logic [8*16-1:0] name;
    md_op_e          op;
    word_t           a;
    word_t           b;
    word_t           expected;
    logic            do_flush;  // Flush mid-operation so no response is expected
  } test_vec_t;

  localparam test_vec_t test_table [num_tests] = '{
    '{"mul_mixed",       op_mul,    32'hFFFF_FFFD, 32'h0000_0007, 32'hFFFF_FFEB, 1'b0},
    '{"mulh_mixed",      op_mulh,   32'hFFFF_FFFD, 32'h0000_0007, 32'hFFFF_FFFF, 1'b0},
    '{"mulhsu_mixed",    op_mulhsu, 32'hFFFF_FFFD, 32'hFFFF_FFFF, 32'hFFFF_FFFD, 1'b0},
    '{"mulhu_mixed",     op_mulhu,  32'hFFFF_FFFD, 32'h0000_0007, 32'h0000_0006, 1'b0},
    '{"mulh_minmin",     op_mulh,   32'h8000_0000, 32'h8000_0000, 32'h4000_0000, 1'b0},
    '{"mulhsu_minmin",   op_mulhsu, 32'h8000_0000, 32'h8000_0000, 32'hC000_0000, 1'b0},
    '{"mulhu_max",       op_mulhu,  32'hFFFF_FFFF, 32'hFFFF_FFFF, 32'hFFFF_FFFE, 1'b0},
    '{"mul_minmin",      op_mul,    32'h8000_0000, 32'h8000_0000, 32'h0000_0000, 1'b0},
    '{"div_pp",          op_div,    32'h0000_0014, 32'h0000_0003, 32'h0000_0006, 1'b0},
    '{"div_np",          op_div,    32'hFFFF_FFEC, 32'h0000_0003, 32'hFFFF_FFFA, 1'b0},
    '{"div_pn",          op_div,    32'h0000_0014, 32'hFFFF_FFFD, 32'hFFFF_FFFA, 1'b0},
    '{"div_nn",          op_div,    32'hFFFF_FFEC, 32'hFFFF_FFFD, 32'h0000_0006, 1'b0},
    '{"rem_pp",          op_rem,    32'h0000_0014, 32'h0000_0003, 32'h0000_0002, 1'b0},
    '{"rem_np",          op_rem,    32'hFFFF_FFEC, 32'h0000_0003, 32'hFFFF_FFFE, 1'b0},
    '{"rem_pn",          op_rem,    32'h0000_0014, 32'hFFFF_FFFD, 32'h0000_0002, 1'b0},
    '{"rem_nn",          op_rem,    32'hFFFF_FFEC, 32'hFFFF_FFFD, 32'hFFFF_FFFE, 1'b0},
    '{"divu_big",        op_divu,   32'hFFFF_FFEC, 32'h0000_0003, 32'h5555_554E, 1'b0},
    '{"remu_big",        op_remu,   32'hFFFF_FFEC, 32'h0000_0003, 32'h0000_0002, 1'b0},
    '{"remu_topbit",     op_remu,   32'hFFFF_FFEC, 32'h8000_0000, 32'h7FFF_FFEC, 1'b0},
    '{"divu_min_ones",   op_divu,   32'h8000_0000, 32'hFFFF_FFFF, 32'h0000_0000, 1'b0},
    '{"div_zero",        op_div,    32'h1234_5678, 32'h0000_0000, 32'hFFFF_FFFF, 1'b0},
    '{"divu_zero",       op_divu,   32'h1234_5678, 32'h0000_0000, 32'hFFFF_FFFF, 1'b0},
    '{"rem_zero",        op_rem,    32'h8765_4321, 32'h0000_0000, 32'h8765_4321, 1'b0},
    '{"remu_zero",       op_remu,   32'h8765_4321, 32'h0000_0000, 32'h8765_4321, 1'b0},
    '{"div_ovf",         op_div,    32'h8000_0000, 32'hFFFF_FFFF, 32'h8000_0000, 1'b0},
    '{"rem_ovf",         op_rem,    32'h8000_0000, 32'hFFFF_FFFF, 32'h0000_0000, 1'b0},
    '{"div_flushed",     op_div,    32'h0000_03E8, 32'h0000_0007, 32'h0000_0000, 1'b1},
    '{"div_after_flush", op_div,    32'h0000_03E8, 32'h0000_0007, 32'h0000_008E, 1'b0},
    '{"rem_after_flush", op_rem,    32'h0000_03E8, 32'h0000_0007, 32'h0000_0006, 1'b0}
  };

  logic        clock = 1'b0;
  logic        reset;
  logic        flush;
  logic        req_valid;
  md_req_t     req;
  logic        req_ready;
  logic        resp_valid;
  md_resp_t    resp;
  logic        timed_out = 1'b0;
  int unsigned checks = 0;
  int unsigned errors = 0;
  int unsigned resp_seen = 0;
  int unsigned resp_expected = 0;

  mdu_top i_dut (
    .clock      (clock),
    .reset      (reset),
    .flush      (flush),
    .req_valid  (req_valid),
    .req        (req),
    .req_ready  (req_ready),
    .resp_valid (resp_valid),
    .resp       (resp)
  );

  always #20 clock = ~clock;

  // Counts every response including unwanted ones
  always @(negedge clock) begin
    if (!reset && resp_valid) begin
      resp_seen <= resp_seen + 1;
    end
  end

  // RISC-V M extension rules on 64-bit arithmetic
  function automatic word_t model_result(md_op_e op, word_t a, word_t b);
    longint          sa;
    longint          sb;
    longint          ub_s;
    longint unsigned ua;
    longint unsigned ub;
    logic [63:0]     prod;
    logic            ovf;
    sa   = longint'($signed(a));
    sb   = longint'($signed(b));
    ua   = {32'b0, a};
    ub   = {32'b0, b};
    ub_s = longint'(ub);
    ovf  = (a == min_word) && (b == ones_word);
    prod = '0;
    case (op)
      op_mul, op_mulh: prod = sa * sb;
      op_mulhsu:       prod = sa * ub_s;
      op_mulhu:        prod = ua * ub;
      default: ;
    endcase
    case (op)
      op_mul:                       return prod[31:0];
      op_mulh, op_mulhsu, op_mulhu: return prod[63:32];
      op_div:  return (b == '0) ? ones_word : (ovf ? a : word_t'(sa / sb));
      op_divu: return (b == '0) ? ones_word : word_t'(ua / ub);
      op_rem:  return (b == '0) ? a : (ovf ? '0 : word_t'(sa % sb));
      default: return (b == '0) ? a : word_t'(ua % ub);
    endcase
  endfunction

  function automatic int unsigned expected_latency(md_op_e op, word_t a, word_t b);
    if (op inside {op_mul, op_mulh, op_mulhsu, op_mulhu}) return 3;
    if (b == '0) return 2;
    if (op inside {op_div, op_rem} && a == min_word && b == ones_word) return 2;
    return 36;
  endfunction

  task automatic report_timeout(string name, string why);
    $display("%0s: %0s", name, why);
    timed_out = 1'b1;
  endtask

  task automatic check_word(string name, string what, word_t expected, word_t actual);
    checks++;
    assert (actual === expected) else begin
      $display("FAIL %0s %0s expected %h actual %h", name, what, expected, actual);
      errors++;
    end
  endtask

  task automatic check_count(string name, string what, int unsigned expected,
                             int unsigned actual);
    checks++;
    assert (actual == expected) else begin
      $display("FAIL %0s %0s expected %0d actual %0d", name, what, expected, actual);
      errors++;
    end
  endtask

  task automatic check_true(string name, logic cond, string what);
    checks++;
    assert (cond === 1'b1) else begin
      $display("FAIL %0s: %0s", name, what);
      errors++;
    end
  endtask

  task automatic run_op(string name, md_op_e op, word_t a, word_t b, word_t expected,
                        logic do_flush);
    int unsigned waited;
    int unsigned errors_before;
    errors_before = errors;
    waited = 0;
    @(negedge clock);
    while (!req_ready) begin
      if (waited == timeout_cycles) begin
        report_timeout(name, "req_ready never came back");
        return;
      end
      @(negedge clock);
      waited++;
    end
    @(posedge clock);
    req_valid <= 1'b1;
    req       <= '{op: op, a: a, b: b};
    @(posedge clock);  // Accepting edge
    req_valid <= 1'b0;
    @(negedge clock);
    check_true(name, !req_ready, "req_ready still high after acceptance");
    if (do_flush) begin
      repeat (10) @(posedge clock);
      flush <= 1'b1;
      @(posedge clock);
      flush <= 1'b0;
      repeat (timeout_cycles / 2) begin  // Well past the divide latency
        @(negedge clock);
        check_true(name, !resp_valid, "response arrived after flush");
      end
      check_true(name, req_ready, "req_ready low after flush");
    end else begin
      resp_expected++;
      waited = 1;
      while (!resp_valid) begin
        if (waited == timeout_cycles) begin
          report_timeout(name, "no response within timeout");
          return;
        end
        @(negedge clock);
        waited++;
      end
      check_true(name, !req_ready, "req_ready high before the response");
      check_word(name, "result", expected, resp.result);
      check_word(name, "op", word_t'(op), word_t'(resp.op));
      check_count(name, "latency", expected_latency(op, a, b), waited);
      @(negedge clock);
      check_true(name, !resp_valid, "resp_valid longer than one cycle");
      check_true(name, req_ready, "req_ready not back after response");
    end
    $display("test %0s: %0s", name, (errors == errors_before) ? "ok" : "errors");
  endtask

  initial begin
    test_vec_t   tv;
    md_op_e      rop;
    word_t       ra;
    word_t       rb;
    int unsigned pick;
    void'($urandom(32'h9534_05df));
    reset     <= 1'b1;
    flush     <= 1'b0;
    req_valid <= 1'b0;
    req       <= '0;
    repeat (16) @(posedge clock);
    reset <= 1'b0;
    @(negedge clock);
    check_true("reset", req_ready, "req_ready low after reset");
    check_true("reset", !resp_valid, "resp_valid high after reset");
    for (int i = 0; i < num_tests && !timed_out; i++) begin
      tv = test_table[i];
      run_op(string'(tv.name), tv.op, tv.a, tv.b, tv.expected, tv.do_flush);
    end
    for (int i = 0; i < num_random && !timed_out; i++) begin
      rop  = md_op_e'($urandom_range(7, 0));
      ra   = $urandom;
      rb   = $urandom;
      pick = $urandom_range(7, 0);
      if (pick == 0) begin
        rb = '0;
      end else if (pick == 1) begin
        rb = rb >> 24;  // Small divisors give long quotients
      end else if (pick == 2) begin
        ra = min_word;
        rb = ones_word;
      end
      run_op($sformatf("rand_%0d", i), rop, ra, rb, model_result(rop, ra, rb), 1'b0);
    end
    repeat (4) @(negedge clock);
    check_count("all", "response count", resp_expected, resp_seen);
    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0 && !timed_out) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
